/* verilog.f */
core_pkg.sv
core_idu.sv
core_regfile.sv
core_exu.sv
core_wbu.sv
core_top.sv
tb_core_assertions.sv
tb_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core
LOG       ?= sim.log
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_core.sv */
`timescale 1ns/1ps

module tb_core;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_INST     = 400;
  localparam int TIMEOUT_NS   = ((NUM_INST + 8) * 4 + RESET_CYCLES) * CLK_PERIOD;
  localparam logic [31:0] EBREAK_INST = 32'h0010_0073;

  logic                      clk;
  logic                      rst_n;
  logic                      inst_valid;
  logic [31:0]               inst;
  logic [core_pkg::XLEN-1:0] pc;
  logic                      commit_valid;
  core_pkg::commit_t         commit;
  logic                      halt;

  logic [63:0]       shadow [32];
  logic [63:0]       model_pc;
  logic [31:0]       lfsr_q;
  core_pkg::commit_t expect_q [$];
  int                errors;
  int                commits;

  core_top core_top_i (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .inst_valid_i   (inst_valid),
    .inst_i         (inst),
    .pc_o           (pc),
    .commit_valid_o (commit_valid),
    .commit_o       (commit),
    .halt_o         (halt)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    int          i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [63:0] a, input logic [63:0] b);
    logic signed [63:0] sa;
    logic        [63:0] res;
    sa = a;
    case (f3)
      3'd0: begin
        if (alt) res = a - b;
        else res = a + b;
      end
      3'd1: res = a << b[5:0];
      3'd2: res = {63'd0, $signed(a) < $signed(b)};
      3'd3: res = {63'd0, a < b};
      3'd4: res = a ^ b;
      3'd5: begin
        if (alt) res = sa >>> b[5:0];
        else res = a >> b[5:0];
      end
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  // Expected commit record from the architectural state before the instruction
  function automatic core_pkg::commit_t ref_commit(input logic [63:0] regs [32],
                                                   input logic [63:0] cur_pc,
                                                   input logic [31:0] ins);
    core_pkg::commit_t c;
    logic [2:0]  f3;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm_i;
    logic [63:0] imm_b;
    logic [63:0] imm_j;
    logic [63:0] imm_u;
    logic        wr;
    logic        legal;
    logic        taken;
    f3    = ins[14:12];
    a     = regs[ins[19:15]];
    b     = regs[ins[24:20]];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
    c.pc      = cur_pc;
    c.next_pc = cur_pc + 64'd4;
    c.rd_idx  = ins[11:7];
    c.rd_data = '0;
    c.illegal = 1'b1;
    wr        = 1'b0;
    case (ins[6:0])
      core_pkg::OPC_R: begin
        legal = (ins[31:25] == 7'h00) || (ins[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        if (legal) begin
          c.illegal = 1'b0;
          wr        = 1'b1;
          c.rd_data = alu_ref(f3, ins[30], a, b);
        end
      end
      core_pkg::OPC_I: begin
        if (f3 == 3'd1) legal = ins[31:26] == 6'h00;
        else if (f3 == 3'd5) legal = ins[31:26] == 6'h00 || ins[31:26] == 6'h10;
        else legal = 1'b1;
        if (legal) begin
          c.illegal = 1'b0;
          wr        = 1'b1;
          c.rd_data = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm_i);
        end
      end
      core_pkg::OPC_LUI: begin
        c.illegal = 1'b0;
        wr        = 1'b1;
        c.rd_data = imm_u;
      end
      core_pkg::OPC_AUIPC: begin
        c.illegal = 1'b0;
        wr        = 1'b1;
        c.rd_data = cur_pc + imm_u;
      end
      core_pkg::OPC_JAL: begin
        c.illegal = 1'b0;
        wr        = 1'b1;
        c.rd_data = cur_pc + 64'd4;
        c.next_pc = cur_pc + imm_j;
      end
      core_pkg::OPC_JALR: begin
        if (f3 == 3'd0) begin
          c.illegal = 1'b0;
          wr        = 1'b1;
          c.rd_data = cur_pc + 64'd4;
          c.next_pc = (a + imm_i) & ~64'd1;
        end
      end
      core_pkg::OPC_BRANCH: begin
        c.illegal = (f3 == 3'd2) || (f3 == 3'd3);
        case (f3)
          3'd0: taken = a == b;
          3'd1: taken = a != b;
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          3'd7: taken = a >= b;
          default: taken = 1'b0;
        endcase
        if (taken) c.next_pc = cur_pc + imm_b;
      end
      core_pkg::OPC_SYSTEM: begin
        if (ins == EBREAK_INST) begin
          c.illegal = 1'b0;
          c.next_pc = cur_pc;
        end
      end
      default: c.illegal = 1'b1;
    endcase
    c.rd_wr_en = wr && (c.rd_idx != 5'd0);
    return c;
  endfunction

  // Uses registers x0 to x3 so that dependencies are frequent
  function automatic logic [31:0] gen_inst();
    logic [3:0]  cls;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    logic [12:0] immb;
    logic [20:0] immj;
    cls   = 4'(take_bits(4));
    rd    = 5'(take_bits(2));
    rs1   = 5'(take_bits(2));
    rs2   = 5'(take_bits(2));
    f3    = 3'(take_bits(3));
    imm12 = 12'(take_bits(12));
    case (cls)
      4'd0, 4'd1, 4'd2, 4'd3: begin
        f7 = 7'h00;
        if ((f3 == 3'd0 || f3 == 3'd5) && take_bits(1) == 32'd1) f7 = 7'h20;
        return {f7, rs2, rs1, f3, rd, core_pkg::OPC_R};
      end
      4'd4, 4'd5, 4'd6, 4'd7: begin
        // Shifts need a clean funct6
        if (f3 == 3'd1) imm12 = {6'h00, imm12[5:0]};
        else if (f3 == 3'd5) imm12 = {1'b0, imm12[11], 4'h0, imm12[5:0]};
        return {imm12, rs1, f3, rd, core_pkg::OPC_I};
      end
      4'd8: return {20'(take_bits(20)), rd, core_pkg::OPC_LUI};
      4'd9: return {20'(take_bits(20)), rd, core_pkg::OPC_AUIPC};
      4'd10: begin
        immj = {20'(take_bits(20)), 1'b0};
        return {immj[20], immj[10:1], immj[11], immj[19:12], rd, core_pkg::OPC_JAL};
      end
      4'd11: return {imm12, rs1, 3'd0, rd, core_pkg::OPC_JALR};
      4'd12, 4'd13: begin
        if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
        immb = {imm12, 1'b0};
        return {immb[12], immb[10:5], rs2, rs1, f3, immb[4:1], immb[11], core_pkg::OPC_BRANCH};
      end
      4'd14: begin
        if (take_bits(1) == 32'd1) return {25'(take_bits(25)), core_pkg::OPC_LOAD};
        return {25'(take_bits(25)), core_pkg::OPC_STORE};
      end
      default: begin
        // M extension encoding or a custom opcode that decode rejects
        if (take_bits(1) == 32'd1) return {7'h01, rs2, rs1, f3, rd, core_pkg::OPC_R};
        return {25'(take_bits(25)), 7'b000_1011};
      end
    endcase
  endfunction

  // Issue one instruction at the current PC and record its expected commit
  task automatic issue(input logic [31:0] ins);
    core_pkg::commit_t exp;
    check_value("pc_o", pc, model_pc);
    exp = ref_commit(shadow, model_pc, ins);
    expect_q.push_back(exp);
    if (exp.rd_wr_en) shadow[exp.rd_idx] = exp.rd_data;
    model_pc   = exp.next_pc;
    inst       = ins;
    inst_valid = 1'b1;
  endtask

  initial begin : compare
    core_pkg::commit_t exp;
    forever begin
      @(negedge clk);
      if (rst_n && commit_valid) begin
        if (expect_q.size() == 0) begin
          $display("Unexpected commit for pc %h while nothing was outstanding", commit.pc);
          errors++;
        end else begin
          exp = expect_q.pop_front();
          check_value("commit_o.pc", commit.pc, exp.pc);
          check_value("commit_o.next_pc", commit.next_pc, exp.next_pc);
          check_value("commit_o.rd_idx", 64'(commit.rd_idx), 64'(exp.rd_idx));
          check_value("commit_o.rd_wr_en", 64'(commit.rd_wr_en), 64'(exp.rd_wr_en));
          check_value("commit_o.illegal", 64'(commit.illegal), 64'(exp.illegal));
          if (exp.rd_wr_en) check_value("commit_o.rd_data", commit.rd_data, exp.rd_data);
          commits++;
        end
      end
    end
  end

  initial begin : stimulus
    int n;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    errors     = 0;
    commits    = 0;
    lfsr_q     = 32'h9918_85f3;
    model_pc   = core_pkg::RESET_PC;
    for (n = 0; n < 32; n++) shadow[n] = '0;

    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_value("pc_o", pc, core_pkg::RESET_PC);
    check_value("commit_valid_o", 64'(commit_valid), 64'd0);
    check_value("halt_o", 64'(halt), 64'd0);

    n = 0;
    while (n < NUM_INST) begin
      @(posedge clk);
      #2;
      if (take_bits(2) == 32'd0) begin
        inst_valid = 1'b0;
      end else begin
        issue(gen_inst());
        n++;
      end
    end

    @(posedge clk);
    #2;
    issue(EBREAK_INST);
    @(posedge clk);
    #2;
    inst_valid = 1'b0;
    check_value("halt_o", 64'(halt), 64'd1);

    // Pulses after the halt must not retire anything
    repeat (4) begin
      @(posedge clk);
      #2;
      inst       = gen_inst();
      inst_valid = 1'b1;
      @(posedge clk);
      #2;
      inst_valid = 1'b0;
      check_value("pc_o", pc, model_pc);
      check_value("halt_o", 64'(halt), 64'd1);
    end
    repeat (3) @(posedge clk);
    #2;

    if (expect_q.size() != 0) begin
      $display("%0d expected commits never appeared", expect_q.size());
      errors++;
    end
    $display("Checked %0d commits with %0d errors", commits, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Watchdog expired before the test finished after %0d ns", TIMEOUT_NS);
    $display("Checked %0d commits with %0d errors", commits, errors);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* tb_core_assertions.sv */
`timescale 1ns/1ps

module tb_core_assertions (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      inst_valid_i,
  input logic [core_pkg::XLEN-1:0] pc_i,
  input logic                      commit_valid_i,
  input logic                      halt_i
);

  // Commit strobe follows an accepted instruction by one cycle
  property commit_after_accept;
    @(posedge clk_i) disable iff (!rst_n_i)
      commit_valid_i |-> $past(inst_valid_i && !halt_i);
  endproperty

  property no_commit_when_halted;
    @(posedge clk_i) disable iff (!rst_n_i)
      (halt_i && $past(halt_i)) |-> !commit_valid_i;
  endproperty

  property pc_aligned;
    @(posedge clk_i) disable iff (!rst_n_i)
      pc_i[0] == 1'b0;
  endproperty

  a_commit_after_accept: assert property (commit_after_accept)
    else $error("commit strobe without an accepted instruction");
  a_no_commit_when_halted: assert property (no_commit_when_halted)
    else $error("commit reported while the core is halted");
  a_pc_aligned: assert property (pc_aligned)
    else $error("pc has bit 0 set");

endmodule

bind core_top tb_core_assertions u_core_assertions (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .inst_valid_i   (inst_valid_i),
  .pc_i           (pc_o),
  .commit_valid_i (commit_valid_o),
  .halt_i         (halt_o)
);

/* core_top.sv */
`timescale 1ns/1ps

module core_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      inst_valid_i,
  input  logic [31:0]               inst_i,
  output logic [core_pkg::XLEN-1:0] pc_o,
  output logic                      commit_valid_o,
  output core_pkg::commit_t         commit_o,
  output logic                      halt_o
);

  logic [core_pkg::REG_IDX_W-1:0] rs1_idx;
  logic [core_pkg::REG_IDX_W-1:0] rs2_idx;
  logic [core_pkg::XLEN-1:0]      rs1_data;
  logic [core_pkg::XLEN-1:0]      rs2_data;

  logic                           rf_wr_en;
  logic [core_pkg::REG_IDX_W-1:0] rf_wr_idx;
  logic [core_pkg::XLEN-1:0]      rf_wr_data;

  core_pkg::dec_out_t dec;
  core_pkg::exe_out_t exe;

  // Decode the fetched instruction at the current PC
  core_idu u_idu (
    .inst_i     (inst_i),
    .pc_i       (pc_o),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_idx_o  (rs1_idx),
    .rs2_idx_o  (rs2_idx),
    .dec_o      (dec)
  );

  core_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .wr_en_i    (rf_wr_en),
    .wr_idx_i   (rf_wr_idx),
    .wr_data_i  (rf_wr_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  core_exu u_exu (
    .dec_i (dec),
    .pc_i  (pc_o),
    .exe_o (exe)
  );

  // Result stage owns the PC and the write port
  core_wbu u_wbu (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .inst_valid_i   (inst_valid_i),
    .exe_i          (exe),
    .pc_o           (pc_o),
    .rf_wr_en_o     (rf_wr_en),
    .rf_wr_idx_o    (rf_wr_idx),
    .rf_wr_data_o   (rf_wr_data),
    .commit_valid_o (commit_valid_o),
    .commit_o       (commit_o),
    .halt_o         (halt_o)
  );

endmodule

/* core_wbu.sv */
`timescale 1ns/1ps

module core_wbu (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           inst_valid_i,
  input  core_pkg::exe_out_t             exe_i,
  output logic [core_pkg::XLEN-1:0]      pc_o,
  output logic                           rf_wr_en_o,
  output logic [core_pkg::REG_IDX_W-1:0] rf_wr_idx_o,
  output logic [core_pkg::XLEN-1:0]      rf_wr_data_o,
  output logic                           commit_valid_o,
  output core_pkg::commit_t              commit_o,
  output logic                           halt_o
);

  logic                      accept;
  logic [core_pkg::XLEN-1:0] pc_q;
  logic                      halt_q;
  logic                      commit_valid_q;
  core_pkg::commit_t         commit_q;

  // Nothing retires once halted
  assign accept = inst_valid_i & ~halt_q;

  assign rf_wr_en_o   = accept & exe_i.rd_wr_en;
  assign rf_wr_idx_o  = exe_i.rd_idx;
  assign rf_wr_data_o = exe_i.result;

  // PC, halt flag and commit strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q           <= core_pkg::RESET_PC;
      halt_q         <= 1'b0;
      commit_valid_q <= 1'b0;
    end else begin
      commit_valid_q <= accept;
      if (accept) begin
        pc_q   <= exe_i.next_pc;
        halt_q <= exe_i.halt;
      end
    end
  end

  // Commit payload captured on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      commit_q.pc       <= pc_q;
      commit_q.next_pc  <= exe_i.next_pc;
      commit_q.rd_idx   <= exe_i.rd_idx;
      commit_q.rd_wr_en <= exe_i.rd_wr_en;
      commit_q.rd_data  <= exe_i.result;
      commit_q.illegal  <= exe_i.illegal;
    end
  end

  assign pc_o           = pc_q;
  assign halt_o         = halt_q;
  assign commit_valid_o = commit_valid_q;
  assign commit_o       = commit_q;

endmodule

/* core_exu.sv */
`timescale 1ns/1ps

module core_exu (
  input  core_pkg::dec_out_t        dec_i,
  input  logic [core_pkg::XLEN-1:0] pc_i,
  output core_pkg::exe_out_t        exe_o
);

  logic [core_pkg::XLEN-1:0] op1;
  logic [core_pkg::XLEN-1:0] op2;
  logic [5:0]                shamt;

  logic [core_pkg::XLEN-1:0] add_res;
  logic [core_pkg::XLEN-1:0] sub_res;
  logic [core_pkg::XLEN-1:0] sll_res;
  logic [core_pkg::XLEN-1:0] srl_res;
  logic [core_pkg::XLEN-1:0] sra_res;
  logic [core_pkg::XLEN-1:0] alu_res;

  logic                      eq;
  logic                      lt;
  logic                      ltu;
  logic                      taken;
  logic                      jump;
  logic [core_pkg::XLEN-1:0] target;
  logic [core_pkg::XLEN-1:0] pc_seq;

  core_pkg::alu_op_t alu;
  core_pkg::bjp_op_t bjp;

  assign op1   = dec_i.op1;
  assign op2   = dec_i.op2;
  assign alu   = dec_i.info.alu;
  assign bjp   = dec_i.info.bjp;
  assign shamt = op2[5:0];

  // Shared adder also forms the jump link value
  assign add_res = op1 + op2;
  assign sub_res = op1 - op2;
  assign sll_res = op1 << shamt;
  assign srl_res = op1 >> shamt;
  assign sra_res = $signed(op1) >>> shamt;

  assign eq  = op1 == op2;
  assign lt  = $signed(op1) < $signed(op2);
  assign ltu = op1 < op2;

  // One-hot select of the ALU result
  assign alu_res = ({64{alu.add}}  & add_res)
                 | ({64{alu.sub}}  & sub_res)
                 | ({64{alu.sll}}  & sll_res)
                 | ({64{alu.slt}}  & {63'd0, lt})
                 | ({64{alu.sltu}} & {63'd0, ltu})
                 | ({64{alu.xor_}} & (op1 ^ op2))
                 | ({64{alu.srl}}  & srl_res)
                 | ({64{alu.sra}}  & sra_res)
                 | ({64{alu.or_}}  & (op1 | op2))
                 | ({64{alu.and_}} & (op1 & op2))
                 | ({64{alu.lui}}  & op2);

  // Branch resolution
  assign taken = (bjp.beq  & eq)
               | (bjp.bne  & ~eq)
               | (bjp.blt  & lt)
               | (bjp.bge  & ~lt)
               | (bjp.bltu & ltu)
               | (bjp.bgeu & ~ltu);
  assign jump  = bjp.jal | bjp.jalr | taken;

  // JALR target has bit 0 cleared
  assign target = (dec_i.op1_jp + dec_i.op2_jp) & ~{63'd0, bjp.jalr};
  assign pc_seq = pc_i + 64'd4;

  always_comb begin
    if (dec_i.info.ebreak) begin
      exe_o.next_pc = pc_i;
    end else if (jump) begin
      exe_o.next_pc = target;
    end else begin
      exe_o.next_pc = pc_seq;
    end
  end

  assign exe_o.result   = dec_i.info.is_bjp ? add_res : alu_res;
  assign exe_o.rd_idx   = dec_i.rd_idx;
  assign exe_o.rd_wr_en = dec_i.rd_wr_en;
  assign exe_o.halt     = dec_i.info.ebreak;
  assign exe_o.illegal  = dec_i.illegal;

endmodule

/* core_regfile.sv */
`timescale 1ns/1ps

module core_regfile (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [core_pkg::REG_IDX_W-1:0] rs1_idx_i,
  input  logic [core_pkg::REG_IDX_W-1:0] rs2_idx_i,
  input  logic                           wr_en_i,
  input  logic [core_pkg::REG_IDX_W-1:0] wr_idx_i,
  input  logic [core_pkg::XLEN-1:0]      wr_data_i,
  output logic [core_pkg::XLEN-1:0]      rs1_data_o,
  output logic [core_pkg::XLEN-1:0]      rs2_data_o
);

  logic [core_pkg::XLEN-1:0] regs_q [core_pkg::NUM_REGS];

  // Decode never enables a write to x0, so it stays zero after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // Combinational reads
  assign rs1_data_o = regs_q[rs1_idx_i];
  assign rs2_data_o = regs_q[rs2_idx_i];

endmodule

/* core_idu.sv */
`timescale 1ns/1ps

module core_idu (
  input  logic [31:0]                    inst_i,
  input  logic [core_pkg::XLEN-1:0]      pc_i,
  input  logic [core_pkg::XLEN-1:0]      rs1_data_i,
  input  logic [core_pkg::XLEN-1:0]      rs2_data_i,
  output logic [core_pkg::REG_IDX_W-1:0] rs1_idx_o,
  output logic [core_pkg::REG_IDX_W-1:0] rs2_idx_o,
  output core_pkg::dec_out_t             dec_o
);

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6;

  logic is_r, is_i, is_load, is_store, is_b;
  logic is_jal, is_jalr, is_lui, is_auipc, is_sys;
  logic f7_zero, f7_alt, f6_zero, f6_alt;

  logic [core_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u, imm;

  core_pkg::alu_op_t alu;
  core_pkg::bjp_op_t bjp;
  logic              ebreak;
  logic              is_alu;
  logic              is_bjp;

  assign opcode = inst_i[6:0];
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  // RV64 shift immediates carry a 6-bit shamt
  assign funct6 = inst_i[31:26];

  assign rs1_idx_o = inst_i[19:15];
  assign rs2_idx_o = inst_i[24:20];

  // Opcode classes
  assign is_r     = opcode == core_pkg::OPC_R;
  assign is_i     = opcode == core_pkg::OPC_I;
  assign is_load  = opcode == core_pkg::OPC_LOAD;
  assign is_store = opcode == core_pkg::OPC_STORE;
  assign is_b     = opcode == core_pkg::OPC_BRANCH;
  assign is_jal   = opcode == core_pkg::OPC_JAL;
  assign is_jalr  = opcode == core_pkg::OPC_JALR;
  assign is_lui   = opcode == core_pkg::OPC_LUI;
  assign is_auipc = opcode == core_pkg::OPC_AUIPC;
  assign is_sys   = opcode == core_pkg::OPC_SYSTEM;

  assign f7_zero = funct7 == 7'b000_0000;
  assign f7_alt  = funct7 == 7'b010_0000;
  assign f6_zero = funct6 == 6'b00_0000;
  assign f6_alt  = funct6 == 6'b01_0000;

  // Immediates sign extended from bit 31
  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_j = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};

  assign imm = ({64{is_i | is_load | is_jalr}} & imm_i)
             | ({64{is_store}}                 & imm_s)
             | ({64{is_b}}                     & imm_b)
             | ({64{is_jal}}                   & imm_j)
             | ({64{is_lui | is_auipc}}        & imm_u);

  // ALU instruction flags for the R and I forms
  assign alu.add  = (is_r & (funct3 == 3'd0) & f7_zero) | (is_i & (funct3 == 3'd0)) | is_auipc;
  assign alu.sub  = is_r & (funct3 == 3'd0) & f7_alt;
  assign alu.sll  = (is_r & (funct3 == 3'd1) & f7_zero) | (is_i & (funct3 == 3'd1) & f6_zero);
  assign alu.slt  = (is_r & (funct3 == 3'd2) & f7_zero) | (is_i & (funct3 == 3'd2));
  assign alu.sltu = (is_r & (funct3 == 3'd3) & f7_zero) | (is_i & (funct3 == 3'd3));
  assign alu.xor_ = (is_r & (funct3 == 3'd4) & f7_zero) | (is_i & (funct3 == 3'd4));
  assign alu.srl  = (is_r & (funct3 == 3'd5) & f7_zero) | (is_i & (funct3 == 3'd5) & f6_zero);
  assign alu.sra  = (is_r & (funct3 == 3'd5) & f7_alt)  | (is_i & (funct3 == 3'd5) & f6_alt);
  assign alu.or_  = (is_r & (funct3 == 3'd6) & f7_zero) | (is_i & (funct3 == 3'd6));
  assign alu.and_ = (is_r & (funct3 == 3'd7) & f7_zero) | (is_i & (funct3 == 3'd7));
  assign alu.lui  = is_lui;

  // Branch and jump flags
  assign bjp.jal  = is_jal;
  assign bjp.jalr = is_jalr & (funct3 == 3'd0);
  assign bjp.beq  = is_b & (funct3 == 3'd0);
  assign bjp.bne  = is_b & (funct3 == 3'd1);
  assign bjp.blt  = is_b & (funct3 == 3'd4);
  assign bjp.bge  = is_b & (funct3 == 3'd5);
  assign bjp.bltu = is_b & (funct3 == 3'd6);
  assign bjp.bgeu = is_b & (funct3 == 3'd7);

  // Only the exact EBREAK encoding is accepted
  assign ebreak = is_sys & (funct3 == 3'd0) & (inst_i[31:20] == 12'd1)
                & (rd == 5'd0) & (inst_i[19:15] == 5'd0);

  assign is_alu = |alu;
  assign is_bjp = |bjp;

  // Operand selection
  assign dec_o.op1 = ({64{is_r | is_i | is_b | is_load | is_store}} & rs1_data_i)
                   | ({64{is_auipc | is_jal | is_jalr}}             & pc_i);

  assign dec_o.op2 = ({64{is_r | is_b}}                               & rs2_data_i)
                   | ({64{is_i | is_load | is_store | is_lui | is_auipc}} & imm)
                   | ({64{is_jal | is_jalr}}                          & 64'd4);

  // Jump target operands
  assign dec_o.op1_jp = ({64{is_jalr}}         & rs1_data_i)
                      | ({64{is_b | is_jal}}   & pc_i);
  assign dec_o.op2_jp = {64{is_b | is_jal | is_jalr}} & imm;

  assign dec_o.rd_idx = rd;
  // Only ALU ops and jumps write rd and never to x0
  assign dec_o.rd_wr_en = (rd != 5'd0) & (is_alu | bjp.jal | bjp.jalr);

  assign dec_o.info.alu    = alu;
  assign dec_o.info.bjp    = bjp;
  assign dec_o.info.is_alu = is_alu;
  assign dec_o.info.is_bjp = is_bjp;
  assign dec_o.info.ebreak = ebreak;

  assign dec_o.illegal = ~(is_alu | is_bjp | ebreak);

endmodule

/* core_pkg.sv */
package core_pkg;

  // Data path and register file geometry
  localparam int XLEN      = 64;
  localparam int REG_IDX_W = 5;
  localparam int NUM_REGS  = 32;

  localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

  // RV64I major opcodes
  localparam logic [6:0] OPC_R      = 7'b011_0011;
  localparam logic [6:0] OPC_I      = 7'b001_0011;
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  // One-hot ALU operation flags
  typedef struct packed {
    logic add;
    logic sub;
    logic sll;
    logic slt;
    logic sltu;
    logic xor_;
    logic srl;
    logic sra;
    logic or_;
    logic and_;
    logic lui;
  } alu_op_t;

  // One-hot branch and jump operation
  typedef struct packed {
    logic jal;
    logic jalr;
    logic beq;
    logic bne;
    logic blt;
    logic bge;
    logic bltu;
    logic bgeu;
  } bjp_op_t;

  typedef struct packed {
    alu_op_t alu;
    bjp_op_t bjp;
    logic    is_alu;
    logic    is_bjp;
    logic    ebreak;
  } exu_info_t;

  // Decode to execute
  typedef struct packed {
    logic [XLEN-1:0]      op1;
    logic [XLEN-1:0]      op2;
    logic [XLEN-1:0]      op1_jp;
    logic [XLEN-1:0]      op2_jp;
    logic [REG_IDX_W-1:0] rd_idx;
    logic                 rd_wr_en;
    exu_info_t            info;
    logic                 illegal;
  } dec_out_t;

  // Execute to result stage
  typedef struct packed {
    logic [XLEN-1:0]      result;
    logic [XLEN-1:0]      next_pc;
    logic [REG_IDX_W-1:0] rd_idx;
    logic                 rd_wr_en;
    logic                 halt;
    logic                 illegal;
  } exe_out_t;

  // One record per retired instruction
  typedef struct packed {
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      next_pc;
    logic [REG_IDX_W-1:0] rd_idx;
    logic                 rd_wr_en;
    logic [XLEN-1:0]      rd_data;
    logic                 illegal;
  } commit_t;

endpackage
